//--- design/err_track_config.svh
`ifndef ERR_TRACK_CONFIG_SVH
`define ERR_TRACK_CONFIG_SVH

// number of receiver lanes in one frame.
`define ET_LANES 4

// width of one signed estimated error.
`define ET_ERR_W 8

// capture RAM address width for 64 words.
`define ET_ADDR_W 6

// three frames with a symbol record and an error record each.
`define ET_REC_PER_SNAP 6

`endif

//--- design/err_track_pkg.sv
`include "err_track_config.svh"

package err_track_pkg;

    typedef struct packed {
        logic [`ET_LANES-1:0]                     prbs_flags;
        logic [`ET_LANES-1:0]                     bits;
        logic [`ET_LANES-1:0][1:0]                sd_flags;
        logic signed [`ET_LANES-1:0][`ET_ERR_W-1:0] est_err;
    } frame_t;

    // index 0 is the oldest frame.
    typedef frame_t [0:2] window_t;

    typedef struct packed {
        logic [32-4*`ET_LANES-1:0]  pad;
        logic [`ET_LANES-1:0]       prbs_flags;
        logic [`ET_LANES-1:0][1:0]  sd_flags;
        logic [`ET_LANES-1:0]       bits;
    } sym_rec_t;

    typedef struct packed {
        logic signed [`ET_LANES-1:0][`ET_ERR_W-1:0] est_err;
    } err_rec_t;

    // even addresses hold symbol records, odd addresses hold error records.
    typedef union packed {
        sym_rec_t sym;
        err_rec_t err;
    } cap_word_u;

    typedef struct packed {
        logic                  valid;
        logic                  we;
        logic [`ET_ADDR_W-1:0] addr;
        cap_word_u             wdata;
    } mem_req_t;

    typedef struct packed {
        logic [`ET_ADDR_W-1:0] addr;
    } rd_req_t;

    typedef struct packed {
        logic      in_range;
        cap_word_u data;
    } rd_rsp_t;

    typedef struct packed {
        logic [7:0]          events;
        logic [7:0]          dropped;
        logic [`ET_ADDR_W:0] fill;
        logic                full;
    } status_t;

endpackage

//--- design/sample_window.sv
`timescale 1ns/1ns
`include "err_track_config.svh"

module sample_window import err_track_pkg::*; (
    input  logic    clk,
    input  logic    rstb,
    input  frame_t  frame_i,
    output window_t window_o,
    output logic    trigger_o
);

    window_t win_q;
    logic    trig_q;

    // frames move from the newest stage at index 2 towards the oldest at index 0.
    always_ff @(posedge clk) begin
        win_q[2] <= frame_i;
        win_q[1] <= win_q[2];
        win_q[0] <= win_q[1];
    end

    // the trigger fires once the flagged frame sits in the oldest stage.
    always_ff @(posedge clk or negedge rstb) begin
        if (!rstb) begin
            trig_q <= 1'b0;
        end else begin
            trig_q <= |win_q[1].prbs_flags; // one cycle after the middle stage.
        end
    end

    assign window_o  = win_q;
    assign trigger_o = trig_q;

    // a trigger must trace back to a flagged frame entering the pipeline.
    a_trigger_has_source : assert property (
        @(posedge clk) disable iff (!rstb)
        trigger_o |-> $past(|win_q[2].prbs_flags, 2)
    ) else $error("trigger without a flagged frame two cycles earlier");

endmodule

//--- design/capture_writer.sv
`timescale 1ns/1ns
`include "err_track_config.svh"

module capture_writer import err_track_pkg::*; (
    input  logic                clk,
    input  logic                rstb,
    input  logic                trigger_i,
    input  window_t             window_i,
    output mem_req_t            wr_req_o,
    output logic [`ET_ADDR_W:0] fill_o,
    output status_t             status_o
);

    localparam logic S_IDLE    = 1'b0;
    localparam logic S_WRITING = 1'b1;

    logic                state_q;
    logic [2:0]          rec_idx_q;
    logic [`ET_ADDR_W:0] fill_q;
    logic [`ET_ADDR_W:0] fill_nxt;
    logic [`ET_ADDR_W:0] wr_addr_full;
    logic [7:0]          events_q;
    logic [7:0]          dropped_q;
    logic                full_q;
    logic                start;
    logic                last_rec;
    window_t             snap_q;
    frame_t              cur_frm;
    cap_word_u           wr_word;

    assign start    = trigger_i && (state_q == S_IDLE) && !full_q;
    assign last_rec = (rec_idx_q == 3'(`ET_REC_PER_SNAP - 1));
    assign fill_nxt = fill_q + (`ET_ADDR_W+1)'(`ET_REC_PER_SNAP);
    assign wr_addr_full = fill_q + (`ET_ADDR_W+1)'(rec_idx_q);

    always_ff @(posedge clk or negedge rstb) begin
        if (!rstb) begin
            state_q   <= S_IDLE;
            rec_idx_q <= '0;
            fill_q    <= '0;
            events_q  <= '0;
            dropped_q <= '0;
            full_q    <= 1'b0;
        end else begin
            if (start) begin
                state_q   <= S_WRITING;
                rec_idx_q <= '0;
                if (events_q != 8'hff) events_q <= events_q + 8'd1;
            end else if (trigger_i && dropped_q != 8'hff) begin
                dropped_q <= dropped_q + 8'd1; // busy or full.
            end
            if (state_q == S_WRITING) begin
                rec_idx_q <= rec_idx_q + 3'd1;
                if (last_rec) begin
                    state_q <= S_IDLE;
                    fill_q  <= fill_nxt;
                    full_q  <= (int'(fill_nxt) + `ET_REC_PER_SNAP > (1 << `ET_ADDR_W));
                end
            end
        end
    end

    // the window is held for the whole snapshot.
    always_ff @(posedge clk) begin
        if (start) snap_q <= window_i;
    end

    assign cur_frm = snap_q[rec_idx_q[2:1]];

    always_comb begin
        wr_word = '0;
        if (rec_idx_q[0]) begin
            wr_word.err.est_err = cur_frm.est_err;
        end else begin
            wr_word.sym.prbs_flags = cur_frm.prbs_flags;
            wr_word.sym.sd_flags   = cur_frm.sd_flags;
            wr_word.sym.bits       = cur_frm.bits;
        end
    end

    assign wr_req_o.valid = (state_q == S_WRITING);
    assign wr_req_o.we    = (state_q == S_WRITING);
    assign wr_req_o.addr  = wr_addr_full[`ET_ADDR_W-1:0];
    assign wr_req_o.wdata = wr_word;

    assign fill_o           = fill_q;
    assign status_o.events  = events_q;
    assign status_o.dropped = dropped_q;
    assign status_o.fill    = fill_q;
    assign status_o.full    = full_q;

    // capture stops before any record could wrap past the top of the RAM.
    a_no_wrap : assert property (
        @(posedge clk) disable iff (!rstb)
        wr_req_o.valid |-> (wr_addr_full < (`ET_ADDR_W+1)'(1 << `ET_ADDR_W))
    ) else $error("capture write address beyond RAM size");

endmodule

//--- design/debug_reader.sv
`timescale 1ns/1ns
`include "err_track_config.svh"

module debug_reader import err_track_pkg::*; (
    input  logic                clk,
    input  logic                rstb,
    input  logic                rd_req_valid_i,
    input  rd_req_t             rd_req_i,
    output logic                rd_req_ready_o,
    output logic                rd_rsp_valid_o,
    output rd_rsp_t             rd_rsp_o,
    input  logic                rd_rsp_ready_i,
    input  logic [`ET_ADDR_W:0] fill_i,
    output mem_req_t            mem_req_o,
    input  logic                mem_gnt_i,
    input  cap_word_u           mem_rdata_i
);

    localparam logic [1:0] S_IDLE = 2'd0;
    localparam logic [1:0] S_REQ  = 2'd1;
    localparam logic [1:0] S_CAP  = 2'd2;
    localparam logic [1:0] S_RSP  = 2'd3;

    logic [1:0]            state_q;
    logic [`ET_ADDR_W-1:0] addr_q;
    rd_rsp_t               rsp_q;

    always_ff @(posedge clk or negedge rstb) begin
        if (!rstb) begin
            state_q <= S_IDLE;
        end else begin
            case (state_q)
                S_IDLE: if (rd_req_valid_i) state_q <= S_REQ;
                S_REQ:  if (mem_gnt_i) state_q <= S_CAP; // waits out capture writes.
                S_CAP:  state_q <= S_RSP;
                S_RSP:  if (rd_rsp_ready_i) state_q <= S_IDLE;
                default: state_q <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state_q == S_IDLE && rd_req_valid_i) begin
            addr_q         <= rd_req_i.addr;
            rsp_q.in_range <= ({1'b0, rd_req_i.addr} < fill_i);
        end
        if (state_q == S_CAP) rsp_q.data <= mem_rdata_i; // RAM data lands one cycle after grant.
    end

    assign rd_req_ready_o  = (state_q == S_IDLE);
    assign rd_rsp_valid_o  = (state_q == S_RSP);
    assign rd_rsp_o        = rsp_q;
    assign mem_req_o.valid = (state_q == S_REQ);
    assign mem_req_o.we    = 1'b0;
    assign mem_req_o.addr  = addr_q;
    assign mem_req_o.wdata = '0;

    // a pending response holds still until the debug port takes it.
    a_rsp_stable : assert property (
        @(posedge clk) disable iff (!rstb)
        rd_rsp_valid_o && !rd_rsp_ready_i |=> rd_rsp_valid_o && $stable(rd_rsp_o)
    ) else $error("debug response changed before it was taken");

endmodule

//--- design/mem_arbiter.sv
`timescale 1ns/1ns
`include "err_track_config.svh"

module mem_arbiter import err_track_pkg::*; (
    input  logic      clk,
    input  logic      rstb,
    input  mem_req_t  wr_req_i,
    input  mem_req_t  rd_req_i,
    output logic      rd_gnt_o,
    output mem_req_t  ram_req_o,
    input  cap_word_u ram_rdata_i,
    output cap_word_u rd_data_o
);

    logic rd_pend_q;

    // the writer always wins, so capture never stalls.
    assign rd_gnt_o = rd_req_i.valid && !wr_req_i.valid;

    always_comb begin
        if (wr_req_i.valid) begin
            ram_req_o = wr_req_i;
        end else if (rd_req_i.valid) begin
            ram_req_o    = rd_req_i;
            ram_req_o.we = 1'b0;
        end else begin
            ram_req_o = '0;
        end
    end

    always_ff @(posedge clk or negedge rstb) begin
        if (!rstb) begin
            rd_pend_q <= 1'b0;
        end else begin
            rd_pend_q <= rd_gnt_o;
        end
    end

    assign rd_data_o = rd_pend_q ? ram_rdata_i : '0; // only granted reads reach the reader.

    // a granted read owns the RAM port and carries the reader's address.
    a_read_owns_port : assert property (
        @(posedge clk) disable iff (!rstb)
        rd_gnt_o |-> ram_req_o.valid && !ram_req_o.we && ram_req_o.addr == rd_req_i.addr
    ) else $error("read grant overlaps a write");

endmodule

//--- design/capture_ram.sv
`timescale 1ns/1ns
`include "err_track_config.svh"

module capture_ram import err_track_pkg::*; (
    input  logic      clk,
    input  mem_req_t  req_i,
    output cap_word_u rdata_o
);

    cap_word_u mem [0:(1 << `ET_ADDR_W)-1];

    always_ff @(posedge clk) begin
        if (req_i.valid) begin
            if (req_i.we) begin
                mem[req_i.addr] <= req_i.wdata;
            end else begin
                rdata_o <= mem[req_i.addr]; // one cycle read latency.
            end
        end
    end

endmodule

//--- design/error_tracker_top.sv
`timescale 1ns/1ns
`include "err_track_config.svh"

module error_tracker_top import err_track_pkg::*; (
    input  logic    clk,
    input  logic    rstb,
    input  frame_t  frame_i,
    input  logic    rd_req_valid_i,
    input  rd_req_t rd_req_i,
    output logic    rd_req_ready_o,
    output logic    rd_rsp_valid_o,
    output rd_rsp_t rd_rsp_o,
    input  logic    rd_rsp_ready_i,
    output status_t status_o
);

    window_t             window;
    logic                trigger;
    mem_req_t            wr_req;
    mem_req_t            rd_mem_req;
    mem_req_t            ram_req;
    logic [`ET_ADDR_W:0] fill;
    logic                rd_gnt;
    cap_word_u           ram_rdata;
    cap_word_u           rd_data;

    sample_window u_window (
        .clk       (clk),
        .rstb      (rstb),
        .frame_i   (frame_i),
        .window_o  (window),
        .trigger_o (trigger)
    );

    capture_writer u_writer (
        .clk       (clk),
        .rstb      (rstb),
        .trigger_i (trigger),
        .window_i  (window),
        .wr_req_o  (wr_req),
        .fill_o    (fill),
        .status_o  (status_o)
    );

    debug_reader u_reader (
        .clk            (clk),
        .rstb           (rstb),
        .rd_req_valid_i (rd_req_valid_i),
        .rd_req_i       (rd_req_i),
        .rd_req_ready_o (rd_req_ready_o),
        .rd_rsp_valid_o (rd_rsp_valid_o),
        .rd_rsp_o       (rd_rsp_o),
        .rd_rsp_ready_i (rd_rsp_ready_i),
        .fill_i         (fill),
        .mem_req_o      (rd_mem_req),
        .mem_gnt_i      (rd_gnt),
        .mem_rdata_i    (rd_data)
    );

    mem_arbiter u_arbiter (
        .clk         (clk),
        .rstb        (rstb),
        .wr_req_i    (wr_req),
        .rd_req_i    (rd_mem_req),
        .rd_gnt_o    (rd_gnt),
        .ram_req_o   (ram_req),
        .ram_rdata_i (ram_rdata),
        .rd_data_o   (rd_data)
    );

    capture_ram u_ram (
        .clk     (clk),
        .req_i   (ram_req),
        .rdata_o (ram_rdata)
    );

endmodule

//--- sim/tb_model.svh
`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

// 32-bit Fibonacci LFSR with taps 32, 22, 2 and 1.
logic [31:0] lfsr_q = 32'd99348;

function automatic logic lfsr_bit();
    logic fb;
    fb = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
    lfsr_q = {lfsr_q[30:0], fb};
    return fb;
endfunction

// builds a random frame with prbs flags only on request and then on at least one lane.
function automatic frame_t make_frame(input logic flagged);
    frame_t f;
    f = '0;
    for (int l = 0; l < `ET_LANES; l++) begin
        if (flagged) f.prbs_flags[l] = lfsr_bit();
        f.bits[l]        = lfsr_bit();
        f.sd_flags[l][1] = lfsr_bit();
        f.sd_flags[l][0] = lfsr_bit();
        for (int b = 0; b < `ET_ERR_W; b++) begin
            f.est_err[l][b] = lfsr_bit();
        end
    end
    if (flagged && f.prbs_flags == '0) f.prbs_flags[0] = 1'b1;
    return f;
endfunction

// the symbol record holds bits, slicer flags and prbs flags with zeros above them.
function automatic cap_word_u pack_sym(input frame_t f);
    sym_rec_t  s;
    cap_word_u w;
    s            = '0;
    s.bits       = f.bits;
    s.sd_flags   = f.sd_flags;
    s.prbs_flags = f.prbs_flags;
    w.sym        = s;
    return w;
endfunction

function automatic cap_word_u pack_err(input frame_t f);
    cap_word_u w;
    w.err.est_err = f.est_err; // all lanes fill the whole word.
    return w;
endfunction

`endif

//--- sim/tb_error_tracker.sv
`timescale 1ns/1ns
`include "err_track_config.svh"

module tb_error_tracker import err_track_pkg::*; ();

    localparam int TIMEOUT = 200;

    logic      clk;
    logic      rstb;
    frame_t    frame_in;
    logic      rd_req_valid;
    rd_req_t   rd_req;
    logic      rd_req_ready;
    logic      rd_rsp_valid;
    rd_rsp_t   rd_rsp;
    logic      rd_rsp_ready;
    status_t   status;
    logic      chk_status;
    logic      chk_idle;
    status_t   exp_status;
    rd_rsp_t   exp_q [$];
    logic      chk_data_q [$];
    rd_rsp_t   exp_head;
    logic      exp_chk;
    frame_t    sent [0:15];
    window_t   snap;
    window_t   tenth;
    int        err_cnt;
    int        test_errs;
    int        pass_cnt;
    int        fail_cnt;

    `include "tb_model.svh"

    error_tracker_top uut (
        .clk            (clk),
        .rstb           (rstb),
        .frame_i        (frame_in),
        .rd_req_valid_i (rd_req_valid),
        .rd_req_i       (rd_req),
        .rd_req_ready_o (rd_req_ready),
        .rd_rsp_valid_o (rd_rsp_valid),
        .rd_rsp_o       (rd_rsp),
        .rd_rsp_ready_i (rd_rsp_ready),
        .status_o       (status)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    a_status : assert property (@(posedge clk) chk_status |-> status == exp_status)
        else begin
            $display("ERR %0t status_o got %h expected %h", $time, $sampled(status),
                     $sampled(exp_status));
            err_cnt++;
        end

    a_idle : assert property (@(posedge clk) chk_idle |-> rd_req_ready && !rd_rsp_valid)
        else begin
            $display("ERR %0t rd_req_ready_o/rd_rsp_valid_o got %b/%b expected 1/0", $time,
                     $sampled(rd_req_ready), $sampled(rd_rsp_valid));
            err_cnt++;
        end

    // data is only compared where the address holds a known record.
    a_rsp_value : assert property (@(posedge clk) disable iff (!rstb)
        rd_rsp_valid && rd_rsp_ready |->
            rd_rsp.in_range === exp_head.in_range && (!exp_chk || rd_rsp.data === exp_head.data))
        else begin
            $display("ERR %0t rd_rsp_o got %h expected %h", $time, $sampled(rd_rsp),
                     $sampled(exp_head));
            err_cnt++;
        end

    a_rsp_held : assert property (@(posedge clk) disable iff (!rstb)
        rd_rsp_valid && !rd_rsp_ready |=> rd_rsp_valid && $stable(rd_rsp))
        else begin
            $display("%0t: debug response changed or vanished before it was taken", $time);
            err_cnt++;
        end

    a_req_blocked : assert property (@(posedge clk) disable iff (!rstb)
        rd_rsp_valid |-> !rd_req_ready)
        else begin
            $display("%0t: debug port took requests while a response was pending", $time);
            err_cnt++;
        end

    task automatic report_timeout(input string what);
        $display("%0t: timeout after %0d cycles waiting for %s", $time, TIMEOUT, what);
        err_cnt++;
    endtask

    task automatic apply_reset();
        @(posedge clk);
        rstb <= 1'b0;
        repeat (3) @(posedge clk);
        rstb <= 1'b1;
    endtask

    task automatic send_burst(input int n, input int f1, input int f2);
        for (int i = 0; i < n; i++) begin
            sent[i] = make_frame(i == f1 || i == f2);
            @(posedge clk);
            frame_in <= sent[i];
        end
        @(posedge clk);
        frame_in <= '0;
        for (int k = 0; k < 3; k++) snap[k] = sent[f1 + k]; // flagged frame and two after it.
    endtask

    task automatic wait_status(input int n_events, input int n_dropped, input int fill_before);
        int t;
        t = 0;
        forever begin
            @(posedge clk);
            if (status.events == n_events && status.dropped == n_dropped &&
                status.fill != fill_before) break;
            t++;
            if (t >= TIMEOUT) begin
                report_timeout("the capture to finish");
                break;
            end
        end
    endtask

    task automatic check_status(input status_t exp);
        @(posedge clk);
        exp_status <= exp;
        chk_status <= 1'b1;
        @(posedge clk);
        chk_status <= 1'b0;
    endtask

    task automatic read_word(input int addr, input logic in_range, input cap_word_u data,
                             input logic chk_data, input int hold);
        rd_rsp_t exp;
        int      t;
        int      held;
        exp.in_range = in_range;
        exp.data     = data;
        exp_q.push_back(exp);
        chk_data_q.push_back(chk_data);
        exp_head = exp_q[0];
        exp_chk  = chk_data_q[0];
        @(posedge clk);
        rd_req_valid <= 1'b1;
        rd_req.addr  <= addr[`ET_ADDR_W-1:0];
        rd_rsp_ready <= (hold == 0);
        t = 0;
        do begin
            @(posedge clk);
            t++;
        end while (!rd_req_ready && t < TIMEOUT);
        if (!rd_req_ready) report_timeout("the debug request to be accepted");
        rd_req_valid <= 1'b0;
        t    = 0;
        held = 0;
        forever begin
            @(posedge clk);
            t++;
            if (rd_rsp_valid && rd_rsp_ready) break;
            if (rd_rsp_valid) held++;
            if (held >= hold) rd_rsp_ready <= 1'b1; // release after the hold period.
            if (t >= TIMEOUT) begin
                report_timeout("the debug response");
                break;
            end
        end
        rd_rsp_ready <= 1'b1;
        void'(exp_q.pop_front());
        void'(chk_data_q.pop_front());
    endtask

    task automatic read_snapshot(input int base, input window_t w);
        for (int k = 0; k < 3; k++) begin
            read_word(base + 2 * k, 1'b1, pack_sym(w[k]), 1'b1, 0);
            read_word(base + 2 * k + 1, 1'b1, pack_err(w[k]), 1'b1, 0);
        end
    endtask

    task automatic end_test(input string name);
        @(posedge clk);
        if (err_cnt == test_errs) begin
            pass_cnt++;
            $display("test %-26s ok", name);
        end else begin
            fail_cnt++;
            $display("test %-26s FAILED with %0d errors", name, err_cnt - test_errs);
        end
        test_errs = err_cnt;
    endtask

    initial begin
        rstb         = 1'b0;
        frame_in     = '0;
        rd_req_valid = 1'b0;
        rd_req       = '0;
        rd_rsp_ready = 1'b1;
        chk_status   = 1'b0;
        chk_idle     = 1'b0;
        exp_status   = '0;
        exp_head     = '0;
        exp_chk      = 1'b0;
        err_cnt      = 0;
        test_errs    = 0;
        pass_cnt     = 0;
        fail_cnt     = 0;
        repeat (3) @(posedge clk);
        rstb <= 1'b1;

        chk_idle <= 1'b1;
        check_status('0);
        chk_idle <= 1'b0;
        end_test("reset state");

        send_burst(8, 1, -1);
        wait_status(1, 0, 0);
        check_status('{8'd1, 8'd0, 7'd6, 1'b0});
        read_snapshot(0, snap);
        end_test("single snapshot");

        send_burst(10, 1, 3); // second flag lands while the writer is busy.
        wait_status(2, 1, 6);
        check_status('{8'd2, 8'd1, 7'd12, 1'b0});
        read_snapshot(6, snap);
        end_test("drop while busy");

        read_word(6, 1'b1, pack_sym(snap[0]), 1'b1, 5);
        read_word(7, 1'b1, pack_err(snap[0]), 1'b1, 0);
        end_test("response backpressure");

        apply_reset();
        for (int i = 0; i < 11; i++) begin
            send_burst(12, 1, -1);
            if (i == 9) tenth = snap;
        end
        wait_status(10, 1, 0);
        check_status('{8'd10, 8'd1, 7'd60, 1'b1});
        read_snapshot(54, tenth);
        end_test("fill to full");

        read_word(60, 1'b0, '0, 1'b0, 0);
        read_word(63, 1'b0, '0, 1'b0, 0);
        read_word(59, 1'b1, pack_err(tenth[2]), 1'b1, 0);
        end_test("read above fill");

        $display("summary: %0d tests ok, %0d tests with errors, %0d errors",
                 pass_cnt, fail_cnt, err_cnt);
        if (err_cnt == 0 && fail_cnt == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

//--- filelist.f
+incdir+design
+incdir+sim
design/err_track_pkg.sv
design/sample_window.sv
design/capture_writer.sv
design/debug_reader.sv
design/mem_arbiter.sv
design/capture_ram.sv
design/error_tracker_top.sv
sim/tb_error_tracker.sv
